//--- verilog/hid_kbd_pkg.sv
// Shared definitions for the HID keyboard to character path
// Boot report, key event and character types
// Slot count, FIFO depth and rollover code
// Modifier byte bit masks
package hid_kbd_pkg;

    localparam int HID_SLOTS      = 6;                      // Key slots per boot report
    localparam int SLOT_IDX_W     = $clog2(HID_SLOTS);      // Scan index width

    localparam int KEY_FIFO_DEPTH = 8;                      // Power of two
    localparam int KEY_FIFO_PTR_W = $clog2(KEY_FIFO_DEPTH);
    localparam int KEY_FIFO_CNT_W = KEY_FIFO_PTR_W + 1;     // Holds 0..depth

    localparam logic [7:0] KEY_ROLLOVER = 8'h01;            // ErrorRollOver usage

    // Modifier byte, one bit per modifier key
    localparam logic [7:0] MOD_LCTRL  = 8'h01;
    localparam logic [7:0] MOD_LSHIFT = 8'h02;
    localparam logic [7:0] MOD_LALT   = 8'h04;
    localparam logic [7:0] MOD_LMETA  = 8'h08;
    localparam logic [7:0] MOD_RCTRL  = 8'h10;
    localparam logic [7:0] MOD_RSHIFT = 8'h20;
    localparam logic [7:0] MOD_RALT   = 8'h40;
    localparam logic [7:0] MOD_RMETA  = 8'h80;

    // Whole boot report without the reserved byte
    typedef struct packed {
        logic [7:0]                mods;                    // Modifier byte
        logic [HID_SLOTS-1:0][7:0] keys;                    // Slot 0 in the low byte
    } hid_report_t;

    // One newly pressed key
    typedef struct packed {
        logic [7:0] mods;
        logic [7:0] code;                                   // Scan code
    } key_event_t;

    typedef logic [7:0] char_t;                             // Output character byte

endpackage

//--- verilog/keymap.sv
// Scan code to character map, Spanish layout
// One key gives one character, priority ctrl, alt, meta, shift, plain
// Codes without an entry pass through unchanged
`timescale 1ns/100ps

module keymap
    import hid_kbd_pkg::*;
(
    input  logic [7:0] i_byte,      // Scan code
    input  logic [7:0] i_mod,       // Modifier byte
    output char_t      o_byte
);

    logic ctrl;
    logic shift;
    logic alt;
    logic meta;
    logic is_letter;

    // Left and right keys act the same
    assign ctrl  = |(i_mod & (MOD_LCTRL  | MOD_RCTRL));
    assign shift = |(i_mod & (MOD_LSHIFT | MOD_RSHIFT));
    assign alt   = |(i_mod & (MOD_LALT   | MOD_RALT));
    assign meta  = |(i_mod & (MOD_LMETA  | MOD_RMETA));

    assign is_letter = (i_byte >= 8'h04) && (i_byte <= 8'h1d);   // a..z

    always_comb begin
        o_byte = i_byte;                        // Default is pass through, 00 stays 00
        if (ctrl) begin
            if (is_letter)
                o_byte = i_byte - 8'h03;        // ^A 01 .. ^Z 1A
        end else if (alt) begin
            case (i_byte)
                8'h1e:   o_byte = "|";          // Key 1
                8'h1f:   o_byte = "@";          // Key 2
                8'h20:   o_byte = "#";          // Key 3
                8'h21:   o_byte = "~";          // Key 4
                8'h35:   o_byte = "\\";
                default: o_byte = i_byte;
            endcase
        end else if (meta) begin
            // Windows key has no table of its own
            o_byte = i_byte;
        end else if (shift) begin
            if (is_letter) begin
                o_byte = i_byte + 8'h3d;        // A .. Z
            end else begin
                case (i_byte)
                    8'h1e:   o_byte = "!";      // Key 1
                    8'h1f:   o_byte = "\"";     // Key 2
                    8'h21:   o_byte = "$";      // Key 4
                    8'h22:   o_byte = "%";      // Key 5
                    8'h23:   o_byte = "&";      // Key 6
                    8'h24:   o_byte = "/";      // Key 7
                    8'h25:   o_byte = "(";      // Key 8
                    8'h26:   o_byte = ")";      // Key 9
                    8'h27:   o_byte = "=";      // Key 0
                    8'h36:   o_byte = ";";
                    8'h37:   o_byte = ":";
                    8'h38:   o_byte = "_";
                    default: o_byte = i_byte;   // Key 3 middle dot is not ASCII
                endcase
            end
        end else begin
            if (is_letter) begin
                o_byte = i_byte + 8'h5d;        // a .. z
            end else begin
                case (i_byte)
                    8'h1e:   o_byte = "1";
                    8'h1f:   o_byte = "2";
                    8'h20:   o_byte = "3";
                    8'h21:   o_byte = "4";
                    8'h22:   o_byte = "5";
                    8'h23:   o_byte = "6";
                    8'h24:   o_byte = "7";
                    8'h25:   o_byte = "8";
                    8'h26:   o_byte = "9";
                    8'h27:   o_byte = "0";
                    8'h28:   o_byte = 8'h0d;    // Return
                    8'h58:   o_byte = 8'h0a;    // Keypad Enter
                    8'h2a:   o_byte = 8'h08;    // Backspace
                    8'h4c:   o_byte = 8'h1f;    // Delete
                    8'h2b:   o_byte = 8'h09;    // Tab
                    8'h2c:   o_byte = " ";      // Space bar
                    8'h36:   o_byte = ",";
                    8'h37:   o_byte = ".";
                    8'h38:   o_byte = "-";
                    default: o_byte = i_byte;
                endcase
            end
        end
    end

endmodule

//--- verilog/hid_report_decoder.sv
// Boot report decoder
// Latches one report, scans its six slots one per cycle and emits
// a key event for every code that was not held in the previous report
// Phantom (rollover) reports are dropped
`timescale 1ns/100ps

module hid_report_decoder
    import hid_kbd_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  hid_report_t i_report,
    input  logic        i_report_valid,
    output logic        o_report_ready,
    output key_event_t  o_event,
    output logic        o_event_valid,
    input  logic        i_event_ready
);

    hid_report_t            r_cur;      // Report under scan
    hid_report_t            r_prev;     // Last fully scanned report
    logic [SLOT_IDX_W-1:0]  r_idx;      // Slot being scanned
    logic                   r_busy;

    logic [7:0] w_code;
    logic       w_seen;
    logic       w_new;
    logic       w_phantom;
    logic       w_accept;
    logic       w_advance;
    logic       w_last;

    assign o_report_ready = !r_busy;
    assign w_accept       = i_report_valid && o_report_ready;

    // All slots hold the rollover code
    always_comb begin
        w_phantom = 1'b1;
        for (int i = 0; i < HID_SLOTS; i++) begin
            if (i_report.keys[i] != KEY_ROLLOVER)
                w_phantom = 1'b0;
        end
    end

    // Compare the current slot with every slot of the previous report
    always_comb begin
        w_code = r_cur.keys[r_idx];
        w_seen = 1'b0;
        for (int i = 0; i < HID_SLOTS; i++) begin
            if (r_prev.keys[i] == w_code)
                w_seen = 1'b1;
        end
    end

    assign w_new     = (w_code != 8'h00) && (w_code != KEY_ROLLOVER) && !w_seen;
    assign w_last    = (r_idx == SLOT_IDX_W'(HID_SLOTS - 1));
    assign w_advance = r_busy && (!w_new || i_event_ready);   // Hold on a stalled event

    assign o_event_valid = r_busy && w_new;
    assign o_event.mods  = r_cur.mods;
    assign o_event.code  = w_code;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            r_busy <= 1'b0;
            r_idx  <= '0;
            r_prev <= '0;
        end else begin
            if (w_accept && !w_phantom)
                r_busy <= 1'b1;                 // Phantom keeps ready high
            if (w_advance) begin
                r_idx <= w_last ? '0 : r_idx + 1'b1;
                if (w_last) begin
                    r_busy <= 1'b0;
                    r_prev <= r_cur;            // Report is now the reference
                end
            end
        end
    end

    // Report payload, no reset needed
    always_ff @(posedge i_clk) begin
        if (w_accept)
            r_cur <= i_report;
    end

    // A stalled event must be held until the FIFO takes it
    a_event_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_event_valid && !i_event_ready |=> o_event_valid && $stable(o_event));

endmodule

//--- verilog/key_fifo.sv
// Synchronous FIFO with a generic payload type
// Circular buffer with read and write pointers and an occupancy count
// Push and pop may happen in the same cycle
`timescale 1ns/100ps

module key_fifo
    import hid_kbd_pkg::*;
#(
    parameter type T = key_event_t
) (
    input  logic i_clk,
    input  logic i_rst_n,
    input  T     i_push_data,
    input  logic i_push_valid,
    output logic o_push_ready,
    output T     o_pop_data,
    output logic o_pop_valid,
    input  logic i_pop_ready
);

    T                          mem [KEY_FIFO_DEPTH];
    logic [KEY_FIFO_PTR_W-1:0] r_wr_ptr;
    logic [KEY_FIFO_PTR_W-1:0] r_rd_ptr;
    logic [KEY_FIFO_CNT_W-1:0] r_count;

    logic w_push;
    logic w_pop;

    assign o_push_ready = (r_count != KEY_FIFO_CNT_W'(KEY_FIFO_DEPTH));   // Not full
    assign o_pop_valid  = (r_count != '0);                                // Not empty
    assign o_pop_data   = mem[r_rd_ptr];

    assign w_push = i_push_valid && o_push_ready;
    assign w_pop  = o_pop_valid && i_pop_ready;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_count  <= '0;
        end else begin
            if (w_push)
                r_wr_ptr <= r_wr_ptr + 1'b1;    // Wraps on power of two depth
            if (w_pop)
                r_rd_ptr <= r_rd_ptr + 1'b1;
            case ({w_push, w_pop})
                2'b10:   r_count <= r_count + 1'b1;
                2'b01:   r_count <= r_count - 1'b1;
                default: r_count <= r_count;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (w_push)
            mem[r_wr_ptr] <= i_push_data;
    end

    a_count_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        r_count <= KEY_FIFO_CNT_W'(KEY_FIFO_DEPTH));

    // Pointer distance tracks the occupancy, so a pop never runs past the last push
    a_no_empty_pop: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        r_count[KEY_FIFO_PTR_W-1:0] == KEY_FIFO_PTR_W'(r_wr_ptr - r_rd_ptr));

endmodule

//--- verilog/char_emitter.sv
// Character output stage
// Maps key events through the keymap into a single output register
// held under back-pressure
`timescale 1ns/100ps

module char_emitter
    import hid_kbd_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  key_event_t i_event,
    input  logic       i_event_valid,
    output logic       o_event_ready,
    output char_t      o_char,
    output logic       o_char_valid,
    input  logic       i_char_ready
);

    char_t w_mapped;
    char_t r_char;
    logic  r_valid;

    keymap keymap_i (
        .i_byte (i_event.code),
        .i_mod  (i_event.mods),
        .o_byte (w_mapped)
    );

    assign o_event_ready = !r_valid || i_char_ready;  // Register empty or draining
    assign o_char        = r_char;
    assign o_char_valid  = r_valid;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            r_valid <= 1'b0;
        end else if (o_event_ready) begin
            r_valid <= i_event_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_event_valid && o_event_ready)
            r_char <= w_mapped;
    end

    a_char_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_char_valid && !i_char_ready |=> o_char_valid && $stable(o_char));

endmodule

//--- verilog/hid_kbd_top.sv
// HID keyboard to character stream top level
// Report decoder, key event FIFO and character stage
`timescale 1ns/100ps

module hid_kbd_top
    import hid_kbd_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  hid_report_t i_report,
    input  logic        i_report_valid,
    output logic        o_report_ready,
    output char_t       o_char,
    output logic        o_char_valid,
    input  logic        i_char_ready
);

    key_event_t dec_event;
    logic       dec_event_valid;
    logic       fifo_push_ready;
    key_event_t fifo_event;
    logic       fifo_event_valid;
    logic       emit_event_ready;

    hid_report_decoder decoder_i (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_report       (i_report),
        .i_report_valid (i_report_valid),
        .o_report_ready (o_report_ready),
        .o_event        (dec_event),
        .o_event_valid  (dec_event_valid),
        .i_event_ready  (fifo_push_ready)
    );

    key_fifo #(
        .T (key_event_t)
    ) fifo_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_push_data  (dec_event),
        .i_push_valid (dec_event_valid),
        .o_push_ready (fifo_push_ready),
        .o_pop_data   (fifo_event),
        .o_pop_valid  (fifo_event_valid),
        .i_pop_ready  (emit_event_ready)
    );

    char_emitter emitter_i (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_event       (fifo_event),
        .i_event_valid (fifo_event_valid),
        .o_event_ready (emit_event_ready),
        .o_char        (o_char),
        .o_char_valid  (o_char_valid),
        .i_char_ready  (i_char_ready)
    );

endmodule

//--- tests/tb_keymap_model.svh
// Reference model for the HID keyboard testbench
// expected_char gives the character for a scan code and modifier byte
// new_key_list gives the newly pressed codes of a report in slot order
`ifndef TB_KEYMAP_MODEL_SVH
`define TB_KEYMAP_MODEL_SVH

typedef logic [7:0] code_q_t[$];

function automatic logic [7:0] expected_char(input logic [7:0] code, input logic [7:0] mods);
    string digit_row;
    string digit_row_sh;
    string punct;
    string punct_sh;
    string alt_row;
    logic  letter;
    digit_row    = "1234567890";
    digit_row_sh = "!\"?$%&/()=";                           // Key 3 handled apart
    punct        = ",.-";
    punct_sh     = ";:_";
    alt_row      = "|@#~";
    letter       = (code >= 8'h04) && (code <= 8'h1d);
    if ((mods & (MOD_LCTRL | MOD_RCTRL)) != 8'h00)
        return letter ? code - 8'h03 : code;                // Control codes
    if ((mods & (MOD_LALT | MOD_RALT)) != 8'h00) begin
        if (code >= 8'h1e && code <= 8'h21)
            return 8'(alt_row.getc(int'(code) - 'h1e));
        return (code == 8'h35) ? 8'h5c : code;              // Backslash
    end
    if ((mods & (MOD_LMETA | MOD_RMETA)) != 8'h00)
        return code;
    if ((mods & (MOD_LSHIFT | MOD_RSHIFT)) != 8'h00) begin
        if (letter)
            return 8'h41 + code - 8'h04;                    // Capitals
        if (code == 8'h20)
            return code;                                    // Middle dot, no ASCII
        if (code >= 8'h1e && code <= 8'h27)
            return 8'(digit_row_sh.getc(int'(code) - 'h1e));
        if (code >= 8'h36 && code <= 8'h38)
            return 8'(punct_sh.getc(int'(code) - 'h36));
        return code;
    end
    if (letter)
        return 8'h61 + code - 8'h04;
    if (code >= 8'h1e && code <= 8'h27)
        return 8'(digit_row.getc(int'(code) - 'h1e));
    if (code >= 8'h36 && code <= 8'h38)
        return 8'(punct.getc(int'(code) - 'h36));
    case (code)
        8'h28:   return 8'h0d;                              // Return
        8'h58:   return 8'h0a;                              // Keypad Enter
        8'h2a:   return 8'h08;                              // Backspace
        8'h4c:   return 8'h1f;                              // Delete
        8'h2b:   return 8'h09;                              // Tab
        8'h2c:   return 8'h20;                              // Space
        default: return code;
    endcase
endfunction

// Codes that are nonzero, not rollover and absent from the previous report
function automatic code_q_t new_key_list(input hid_report_t cur, input hid_report_t prev);
    code_q_t codes;
    logic    held;
    for (int s = 0; s < HID_SLOTS; s++) begin
        held = 1'b0;
        for (int p = 0; p < HID_SLOTS; p++)
            held = held || (prev.keys[p] == cur.keys[s]);
        if (cur.keys[s] != 8'h00 && cur.keys[s] != KEY_ROLLOVER && !held)
            codes.push_back(cur.keys[s]);
    end
    return codes;
endfunction

`endif

//--- tests/tb_hid_kbd.sv
// Testbench for the HID keyboard to character path
// Clock, reset, directed tests, value check and closing report
`timescale 1ns/100ps

module tb_hid_kbd
    import hid_kbd_pkg::*;
();

    localparam int TIMEOUT = 400;                   // Cycles per wait loop

    logic        i_clk;
    logic        i_rst_n;
    hid_report_t i_report;
    logic        i_report_valid;
    logic        o_report_ready;
    char_t       o_char;
    logic        o_char_valid;
    logic        i_char_ready;

    logic [7:0]   exp_q[$];
    logic [7:0]   got_q[$];
    hid_report_t  prev_rep;                         // Reference for new keys
    logic         stall_en;
    logic [255:0] stall_pat;
    logic [7:0]   cyc;
    int           err_count;
    int           timeout_count;

    `include "tb_keymap_model.svh"

    hid_kbd_top dut_i (.*);

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    // Output ready, random low cycles while stalling
    initial begin
        i_char_ready = 1'b1;
        cyc          = '0;
        forever begin
            @(posedge i_clk);
            #1;
            i_char_ready = !stall_en || stall_pat[cyc];
            cyc          = cyc + 1'b1;
        end
    end

    // Sampled mid-cycle, transfer happens at the next rising edge
    always @(negedge i_clk) begin
        if (i_rst_n && o_char_valid && i_char_ready)
            got_q.push_back(o_char);
    end

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string name);
        if (got !== exp) begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            err_count++;
        end
    endtask

    function automatic logic [47:0] one_key(input logic [7:0] code);
        return {40'h0, code};
    endfunction

    function automatic logic [47:0] key_slots(input logic [7:0] s0, input logic [7:0] s1,
                                              input logic [7:0] s2, input logic [7:0] s3,
                                              input logic [7:0] s4, input logic [7:0] s5);
        return {s5, s4, s3, s2, s1, s0};            // Slot 0 in the low byte
    endfunction

    task automatic send_report(input logic [7:0] mods, input logic [47:0] keys);
        hid_report_t rep;
        code_q_t     codes;
        int          cnt;
        rep.mods = mods;
        rep.keys = keys;
        if (rep.keys != {HID_SLOTS{KEY_ROLLOVER}}) begin  // Phantom keeps the reference
            codes = new_key_list(rep, prev_rep);
            foreach (codes[i])
                exp_q.push_back(expected_char(codes[i], mods));
            prev_rep = rep;
        end
        i_report       = rep;
        i_report_valid = 1'b1;
        cnt            = 0;
        while (!o_report_ready && cnt < TIMEOUT) begin
            @(posedge i_clk);
            #1;
            cnt++;
        end
        if (!o_report_ready) begin
            $display("Timeout: the report input never became ready");
            timeout_count++;
        end
        @(posedge i_clk);
        #1;
        i_report_valid = 1'b0;
    endtask

    task automatic expect_chars(input string what);
        int cnt;
        cnt = 0;
        while ((got_q.size() < exp_q.size() || !o_report_ready) && cnt < TIMEOUT) begin
            @(posedge i_clk);
            #1;
            cnt++;
        end
        if (cnt >= TIMEOUT) begin
            $display("Timeout: %s, the characters did not all arrive", what);
            timeout_count++;
        end
        stall_en = 1'b0;
        repeat (12) @(posedge i_clk);               // Room for a stray extra character
        #1;
        check(32'(got_q.size()), 32'(exp_q.size()), {what, " character count"});
        foreach (exp_q[i])
            if (i < got_q.size())
                check(32'(got_q[i]), 32'(exp_q[i]), "o_char");
        exp_q.delete();
        got_q.delete();
    endtask

    task automatic test_reset_state();
        for (int i = 0; i < 5; i++) begin
            check(32'(o_char_valid), 32'h0, "o_char_valid");
            check(32'(o_report_ready), 32'h1, "o_report_ready");
            @(posedge i_clk);
            #1;
        end
    endtask

    task automatic test_plain_shift();
        logic [7:0] codes[$];
        codes = {8'h28, 8'h58, 8'h2a, 8'h4c, 8'h2b, 8'h2c, 8'h36, 8'h37, 8'h38};
        for (int c = 'h04; c <= 'h27; c++)
            codes.push_back(8'(c));
        foreach (codes[i]) begin
            send_report(8'h00, one_key(codes[i]));
            send_report(8'h00, '0);
            send_report(MOD_LSHIFT, one_key(codes[i]));
            send_report(8'h00, '0);
            send_report(MOD_RSHIFT, one_key(codes[i]));
            send_report(8'h00, '0);
        end
        expect_chars("plain and shift");
    endtask

    task automatic test_modifiers();
        logic [7:0] alt_codes[5] = '{8'h1e, 8'h1f, 8'h20, 8'h21, 8'h35};
        logic [7:0] mix_mods[6]  = '{MOD_LMETA, MOD_RMETA | MOD_LSHIFT, MOD_LCTRL | MOD_LALT,
                                     MOD_LCTRL | MOD_RALT, MOD_LALT | MOD_LSHIFT, 8'h00};
        logic [7:0] mix_codes[6] = '{8'h04, 8'h05, 8'h06, 8'h1e, 8'h1f, 8'h3a};
        for (int c = 'h04; c <= 'h1d; c++) begin
            send_report((c % 2 != 0) ? MOD_RCTRL : MOD_LCTRL, one_key(8'(c)));
            send_report(8'h00, '0);
        end
        foreach (alt_codes[i]) begin
            send_report((i % 2 != 0) ? MOD_RALT : MOD_LALT, one_key(alt_codes[i]));
            send_report(8'h00, '0);
        end
        foreach (mix_codes[i]) begin
            send_report(mix_mods[i], one_key(mix_codes[i]));
            send_report(8'h00, '0);
        end
        expect_chars("modifier priority");
    endtask

    task automatic test_new_keys();
        send_report(8'h00, one_key(8'h04));
        send_report(8'h00, key_slots(8'h04, 8'h05, 8'h00, 8'h00, 8'h00, 8'h00));
        send_report(8'h00, key_slots(8'h05, 8'h00, 8'h04, 8'h00, 8'h00, 8'h00));
        send_report(8'h00, key_slots(8'h00, 8'h07, 8'h05, 8'h00, 8'h06, 8'h04));
        send_report(MOD_LSHIFT, key_slots(8'h08, 8'h07, 8'h00, 8'h09, 8'h06, 8'h00));
        send_report(8'h00, '0);
        expect_chars("new keys");
    endtask

    task automatic test_phantom();
        send_report(8'h00, one_key(8'h0a));
        send_report(8'h00, {HID_SLOTS{KEY_ROLLOVER}});
        send_report(8'h00, key_slots(8'h0a, 8'h0b, 8'h00, 8'h00, 8'h00, 8'h00));
        send_report(8'h00, '0);
        expect_chars("phantom report");
    endtask

    task automatic test_backpressure();
        logic [47:0] keys;
        stall_en = 1'b1;
        for (int r = 0; r < 40; r++) begin
            for (int s = 0; s < HID_SLOTS; s++)
                keys[s*8 +: 8] = ($urandom % 4 == 0) ? 8'h00 : 8'(8'h04 + $urandom % 26);
            send_report((r % 3 == 0) ? MOD_LSHIFT : 8'h00, keys);
        end
        send_report(8'h00, '0);
        expect_chars("back-pressure");
    endtask

    initial begin
        void'($urandom(32'hc0a2_bb4a));
        for (int i = 0; i < 256; i++)
            stall_pat[i] = ($urandom % 3) == 0;     // Ready about one cycle in three, FIFO fills
        i_rst_n        = 1'b0;
        i_report       = '0;
        i_report_valid = 1'b0;
        stall_en       = 1'b0;
        prev_rep       = '0;
        err_count      = 0;
        timeout_count  = 0;
        repeat (10) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;
        test_reset_state();
        test_plain_shift();
        test_modifiers();
        test_new_keys();
        test_phantom();
        test_backpressure();
        $display("Run complete: %0d value errors, %0d timeouts", err_count, timeout_count);
        if (err_count == 0 && timeout_count == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- src.f
+incdir+tests
verilog/hid_kbd_pkg.sv
verilog/keymap.sv
verilog/hid_report_decoder.sv
verilog/key_fifo.sv
verilog/char_emitter.sv
verilog/hid_kbd_top.sv
tests/tb_hid_kbd.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_hid_kbd
FILELIST = src.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
